// File: hdl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                  clk,
    input  logic                  rst_i,
    input  rv_core_pkg::reg_idx_t rs1_i,
    input  rv_core_pkg::reg_idx_t rs2_i,
    output rv_core_pkg::rv_word_t rd1_o,
    output rv_core_pkg::rv_word_t rd2_o,
    input  logic                  we_i,
    input  rv_core_pkg::reg_idx_t wa_i,
    input  rv_core_pkg::rv_word_t wd_i
);

    import rv_core_pkg::*;

    rv_word_t regs_q [32];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin
            regs_q[wa_i] <= wd_i;
        end
    end

    // x0 always reads as zero
    assign rd1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rd2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

// File: hdl/reorder_buffer.sv
`timescale 1ns/10ps
`include "rv_core_config.svh"

module reorder_buffer (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    alloc_valid_i,
    input  rv_core_pkg::reg_idx_t   alloc_rd_i,
    output rv_core_pkg::rob_tag_t   alloc_tag_o,
    output logic                    full_o,
    output logic [31:0]             busy_mask_o,
    input  rv_core_pkg::wb_result_t wb_i,
    output logic                    commit_req_o,
    input  logic                    commit_ack_i,
    output rv_core_pkg::commit_t    commit_o,
    output logic                    rf_we_o,
    output rv_core_pkg::reg_idx_t   rf_wa_o,
    output rv_core_pkg::rv_word_t   rf_wd_o
);

    import rv_core_pkg::*;

    reg_idx_t slot_rd_q  [`ROB_ENTRIES];
    rv_word_t slot_val_q [`ROB_ENTRIES];
    logic [`ROB_ENTRIES-1:0] slot_done_q;
    logic [`ROB_ENTRIES-1:0] slot_used;

    rob_tag_t             head_q;
    rob_tag_t             tail_q;
    logic [ROB_TAG_W:0]   count_q;
    logic                 do_alloc;
    logic                 do_commit;
    logic                 head_done;

    assign full_o      = (count_q == (ROB_TAG_W + 1)'(`ROB_ENTRIES));
    assign alloc_tag_o = tail_q;
    assign do_alloc    = alloc_valid_i && !full_o;
    assign head_done   = (count_q != '0) && slot_done_q[head_q];
    assign do_commit   = commit_req_o && commit_ack_i;

    // Slot is live when it sits within count entries of the head
    always_comb begin
        busy_mask_o = '0;
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
            slot_used[i] = rob_tag_t'(rob_tag_t'(i) - head_q) < count_q;
            if (slot_used[i] && slot_rd_q[i] != '0) begin
                busy_mask_o[slot_rd_q[i]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            slot_done_q  <= '0;
            commit_req_o <= 1'b0;
        end else begin
            if (do_commit) begin
                slot_done_q[head_q] <= 1'b0;
                head_q              <= head_q + 1'b1;
                commit_req_o        <= 1'b0;
            end else if (!commit_req_o && head_done && !commit_ack_i) begin
                commit_req_o <= 1'b1;
            end
            if (do_alloc) begin
                slot_done_q[tail_q] <= 1'b0;
                tail_q              <= tail_q + 1'b1;
            end
            if (wb_i.valid) begin
                slot_done_q[wb_i.tag] <= 1'b1;
            end
            count_q <= count_q + do_alloc - do_commit;
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            slot_rd_q[tail_q] <= alloc_rd_i;
        end
        if (wb_i.valid) begin
            slot_val_q[wb_i.tag] <= wb_i.value;
        end
    end

    always_comb begin
        commit_o.tag   = head_q;
        commit_o.rd    = slot_rd_q[head_q];
        commit_o.value = slot_val_q[head_q];
    end

    // Register file write happens on the ack cycle
    assign rf_we_o = do_commit;
    assign rf_wa_o = slot_rd_q[head_q];
    assign rf_wd_o = slot_val_q[head_q];

endmodule

// File: hdl/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Reorder buffer slot count as a power of two
`define ROB_ENTRIES 8

// Cycles from shifter accept to result on the writeback bus
`define SHIFT_LATENCY 4

`endif

// File: hdl/rv_core_pkg.sv
`include "rv_core_config.svh"

package rv_core_pkg;

    localparam int ROB_TAG_W = $clog2(`ROB_ENTRIES);

    // RV32I opcodes handled by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef logic [31:0] rv_word_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // One instruction word read through two field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        alu_op_e  op;
        rv_word_t a;
        rv_word_t b;
    } issue_op_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        rv_word_t value;
    } wb_result_t;

    typedef struct packed {
        rob_tag_t tag;
        reg_idx_t rd;
        rv_word_t value;
    } commit_t;

endpackage

// File: hdl/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  issue_req_i,
    input  rv_core_pkg::rv_word_t issue_instr_i,
    output logic                  issue_ack_o,
    output logic                  commit_req_o,
    input  logic                  commit_ack_i,
    output rv_core_pkg::commit_t  commit_o
);

    import rv_core_pkg::*;

    reg_idx_t    rs1;
    reg_idx_t    rs2;
    rv_word_t    rd1;
    rv_word_t    rd2;
    logic [31:0] busy_mask;
    logic        rob_full;
    rob_tag_t    alloc_tag;
    logic        alloc_valid;
    reg_idx_t    alloc_rd;
    logic        exec_ready;
    issue_op_t   issue_op;
    wb_result_t  wb;
    logic        rf_we;
    reg_idx_t    rf_wa;
    rv_word_t    rf_wd;

    reg_file u_reg_file (
        .clk   (clk),
        .rst_i (rst_i),
        .rs1_i (rs1),
        .rs2_i (rs2),
        .rd1_o (rd1),
        .rd2_o (rd2),
        .we_i  (rf_we),
        .wa_i  (rf_wa),
        .wd_i  (rf_wd)
    );

    rv_decode u_decode (
        .clk           (clk),
        .rst_i         (rst_i),
        .issue_req_i   (issue_req_i),
        .issue_instr_i (issue_instr_i),
        .issue_ack_o   (issue_ack_o),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rd1_i         (rd1),
        .rd2_i         (rd2),
        .busy_mask_i   (busy_mask),
        .rob_full_i    (rob_full),
        .alloc_tag_i   (alloc_tag),
        .alloc_valid_o (alloc_valid),
        .alloc_rd_o    (alloc_rd),
        .exec_ready_i  (exec_ready),
        .op_o          (issue_op)
    );

    rv_execute u_execute (
        .clk          (clk),
        .rst_i        (rst_i),
        .op_i         (issue_op),
        .exec_ready_o (exec_ready),
        .wb_o         (wb)
    );

    reorder_buffer u_rob (
        .clk           (clk),
        .rst_i         (rst_i),
        .alloc_valid_i (alloc_valid),
        .alloc_rd_i    (alloc_rd),
        .alloc_tag_o   (alloc_tag),
        .full_o        (rob_full),
        .busy_mask_o   (busy_mask),
        .wb_i          (wb),
        .commit_req_o  (commit_req_o),
        .commit_ack_i  (commit_ack_i),
        .commit_o      (commit_o),
        .rf_we_o       (rf_we),
        .rf_wa_o       (rf_wa),
        .rf_wd_o       (rf_wd)
    );

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   issue_req_i,
    input  rv_core_pkg::rv_word_t  issue_instr_i,
    output logic                   issue_ack_o,
    output rv_core_pkg::reg_idx_t  rs1_o,
    output rv_core_pkg::reg_idx_t  rs2_o,
    input  rv_core_pkg::rv_word_t  rd1_i,
    input  rv_core_pkg::rv_word_t  rd2_i,
    input  logic [31:0]            busy_mask_i,
    input  logic                   rob_full_i,
    input  rv_core_pkg::rob_tag_t  alloc_tag_i,
    output logic                   alloc_valid_o,
    output rv_core_pkg::reg_idx_t  alloc_rd_o,
    input  logic                   exec_ready_i,
    output rv_core_pkg::issue_op_t op_o
);

    import rv_core_pkg::*;

    instr_u   instr;
    logic     is_rtype;
    rv_word_t imm_ext;
    alu_op_e  op;
    logic     src_busy;
    logic     fire;

    assign instr    = instr_u'(issue_instr_i);
    assign is_rtype = (instr.r.opcode == OPC_OP);
    assign imm_ext  = {{20{instr.i.imm[11]}}, instr.i.imm};

    assign rs1_o = instr.r.rs1;
    assign rs2_o = instr.r.rs2;

    // funct7 only distinguishes sub from add on the register form
    always_comb begin
        case (instr.r.funct3)
            3'b000:  op = (is_rtype && instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b100:  op = ALU_XOR;
            3'b101:  op = ALU_SRL;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
    end

    // rs2 bits are immediate bits in I-type words
    assign src_busy = busy_mask_i[instr.r.rs1] || (is_rtype && busy_mask_i[instr.r.rs2]);

    assign fire = issue_req_i && !issue_ack_o && !src_busy && !rob_full_i && exec_ready_i;

    assign alloc_valid_o = fire;
    assign alloc_rd_o    = instr.r.rd;

    always_comb begin
        op_o.valid = fire;
        op_o.tag   = alloc_tag_i;
        op_o.op    = op;
        op_o.a     = rd1_i;
        op_o.b     = is_rtype ? rd2_i : imm_ext;
    end

    // Ack side of the issue handshake
    always_ff @(posedge clk) begin
        if (rst_i) begin
            issue_ack_o <= 1'b0;
        end else if (fire) begin
            issue_ack_o <= 1'b1;
        end else if (!issue_req_i) begin
            issue_ack_o <= 1'b0;
        end
    end

endmodule

// File: hdl/rv_execute.sv
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_execute (
    input  logic                    clk,
    input  logic                    rst_i,
    input  rv_core_pkg::issue_op_t  op_i,
    output logic                    exec_ready_o,
    output rv_core_pkg::wb_result_t wb_o
);

    import rv_core_pkg::*;

    localparam int CNT_W = $clog2(`SHIFT_LATENCY + 1);

    logic     is_shift;
    logic     alu_valid_q;
    rob_tag_t alu_tag_q;
    rv_word_t alu_val_q;
    logic     sh_busy_q;
    logic [CNT_W-1:0] sh_cnt_q;
    rob_tag_t sh_tag_q;
    rv_word_t sh_val_q;
    logic     sh_done;

    assign is_shift = (op_i.op == ALU_SLL) || (op_i.op == ALU_SRL);

    // Shifter takes one op at a time, ALU always accepts
    assign exec_ready_o = !(is_shift && sh_busy_q);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            alu_valid_q <= 1'b0;
        end else begin
            alu_valid_q <= op_i.valid && !is_shift;
        end
    end

    always_ff @(posedge clk) begin
        alu_tag_q <= op_i.tag;
        case (op_i.op)
            ALU_ADD: alu_val_q <= op_i.a + op_i.b;
            ALU_SUB: alu_val_q <= op_i.a - op_i.b;
            ALU_AND: alu_val_q <= op_i.a & op_i.b;
            ALU_OR:  alu_val_q <= op_i.a | op_i.b;
            ALU_XOR: alu_val_q <= op_i.a ^ op_i.b;
            default: alu_val_q <= '0;
        endcase
    end

    // Count reaches zero on the result cycle and stays there while parked
    assign sh_done = sh_busy_q && (sh_cnt_q == '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sh_busy_q <= 1'b0;
            sh_cnt_q  <= '0;
        end else if (op_i.valid && is_shift && !sh_busy_q) begin
            sh_busy_q <= 1'b1;
            sh_cnt_q  <= CNT_W'(`SHIFT_LATENCY - 1);
        end else if (sh_busy_q) begin
            if (sh_cnt_q != '0) begin
                sh_cnt_q <= sh_cnt_q - 1'b1;
            end else if (!alu_valid_q) begin
                sh_busy_q <= 1'b0;
            end
        end
    end

    // Result computed at accept, held until the countdown ends
    always_ff @(posedge clk) begin
        if (op_i.valid && is_shift && !sh_busy_q) begin
            sh_tag_q <= op_i.tag;
            sh_val_q <= (op_i.op == ALU_SLL) ? (op_i.a << op_i.b[4:0])
                                             : (op_i.a >> op_i.b[4:0]);
        end
    end

    // ALU has priority on the writeback bus
    always_comb begin
        wb_o.valid = alu_valid_q || sh_done;
        wb_o.tag   = alu_valid_q ? alu_tag_q : sh_tag_q;
        wb_o.value = alu_valid_q ? alu_val_q : sh_val_q;
    end

endmodule

// File: list.f
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/reg_file.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/reorder_buffer.sv
hdl/rv_core_top.sv
verification/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f list.f --top-module rv_core_tb -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
echo "simulation finished without failures"

// File: verification/rv_core_tb.sv
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_core_tb;

    import rv_core_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam int BP_TEST    = 5;
    localparam int SIG_ACK    = 0;
    localparam int SIG_CREQ   = 1;

    logic     clk;
    logic     rst_i;
    logic     issue_req_i;
    rv_word_t issue_instr_i;
    logic     issue_ack_o;
    logic     commit_req_o;
    logic     commit_ack_i;
    commit_t  commit_o;

    // Trace columns with one entry per instruction
    int       test_q[$];
    rv_word_t instr_q[$];
    reg_idx_t rd_q[$];
    rv_word_t value_q[$];

    int errors;
    int checks;
    int tests_done;
    bit aborted;

    rv_core_top DUT (
        .clk           (clk),
        .rst_i         (rst_i),
        .issue_req_i   (issue_req_i),
        .issue_instr_i (issue_instr_i),
        .issue_ack_o   (issue_ack_o),
        .commit_req_o  (commit_req_o),
        .commit_ack_i  (commit_ack_i),
        .commit_o      (commit_o)
    );

    always #4 clk = ~clk;

    task automatic load_trace();
        int       fd;
        int       t;
        int       rd;
        string    line;
        rv_word_t instr;
        rv_word_t value;
        fd = $fopen("verification/rv_core_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file verification/rv_core_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip blank and comment lines
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%d %h %d %h", t, instr, rd, value) == 4) begin
                        test_q.push_back(t);
                        instr_q.push_back(instr);
                        rd_q.push_back(reg_idx_t'(rd));
                        value_q.push_back(value);
                    end
                end
            end
            $fclose(fd);
            if (test_q.size() == 0) begin
                $display("The trace file holds no instructions");
                errors++;
            end
        end
    endtask

    // Polls one DUT output once per cycle at 1 ns after the edge
    task automatic wait_for(input int sel, input logic level, input string what);
        int cycles;
        cycles = 0;
        while (!aborted && ((sel == SIG_ACK) ? issue_ack_o : commit_req_o) !== level) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout at %0t: %s did not come within %0d cycles",
                         $time, what, WAIT_LIMIT);
                aborted = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic check_word(input rv_word_t got, input rv_word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp, input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: commit %0d got %0d/x%0d/%h, expected %0d/x%0d/%h",
                     $time, idx, got.tag, got.rd, got.value, exp.tag, exp.rd, exp.value);
        end
    endtask

    task automatic report_test(input int num, input int count, input int errs);
        tests_done++;
        $display("test %0d finished: %0d checks, %0d errors", num, count, errs);
    endtask

    task automatic issue_all();
        for (int n = 0; n < instr_q.size() && !aborted; n++) begin
            issue_instr_i = instr_q[n];
            issue_req_i   = 1'b1;
            wait_for(SIG_ACK, 1'b1, "issue ack");
            issue_req_i = 1'b0;
            wait_for(SIG_ACK, 1'b0, "issue ack release");
        end
    endtask

    task automatic commit_all();
        commit_t expect_q[$];
        commit_t exp;
        int      delay;
        int      base_err;
        int      count;
        // Tags follow program order modulo the buffer depth
        for (int n = 0; n < test_q.size(); n++) begin
            exp.tag   = rob_tag_t'(n % `ROB_ENTRIES);
            exp.rd    = rd_q[n];
            exp.value = value_q[n];
            expect_q.push_back(exp);
        end
        base_err = errors;
        count    = 0;
        for (int n = 0; n < test_q.size() && !aborted; n++) begin
            exp = expect_q.pop_front();
            wait_for(SIG_CREQ, 1'b1, "commit request");
            if (!aborted) begin
                if (test_q[n] == BP_TEST) begin
                    delay = $urandom % 7;
                    repeat (delay) begin
                        @(posedge clk);
                        #1;
                    end
                end
                check_commit(commit_o, exp, n);
                count++;
                commit_ack_i = 1'b1;
                wait_for(SIG_CREQ, 1'b0, "commit request release");
                commit_ack_i = 1'b0;
            end
            if (n == test_q.size() - 1 || test_q[n + 1] != test_q[n]) begin
                report_test(test_q[n], count, errors - base_err);
                base_err = errors;
                count    = 0;
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_i         = 1'b1;
        issue_req_i   = 1'b0;
        issue_instr_i = '0;
        commit_ack_i  = 1'b0;
        errors        = 0;
        checks        = 0;
        tests_done    = 0;
        aborted       = 1'b0;
        void'($urandom(86));
        load_trace();

        repeat (5) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // Handshake outputs idle after reset
        check_word({31'b0, issue_ack_o}, '0, "issue_ack_o after reset");
        check_word({31'b0, commit_req_o}, '0, "commit_req_o after reset");
        report_test(1, checks, errors);

        fork
            issue_all();
            commit_all();
        join

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verification/rv_core_trace.txt
# test  instruction  expected_rd  expected_value   (test and rd in decimal, rest in hex)
# Registers start at zero, values follow RV32I semantics in trace order
2 06400093 1  00000064
2 ff900113 2  fffffff9
2 5a504193 3  000005a5
2 0f006213 4  000000f0
2 80000293 5  fffff800
2 00208333 6  0000005d
2 402083b3 7  0000006b
2 0041f433 8  000000a0
2 0041e4b3 9  000005f5
2 0020c533 10 ffffff9d
3 00409593 11 00000640
3 00100613 12 00000001
3 00200693 13 00000002
3 fff04713 14 ffffffff
3 12306793 15 00000123
4 01c75813 16 0000000f
4 010808b3 17 0000001e
4 00c89933 18 0000003c
4 40d909b3 19 0000003a
4 01375a33 20 0000003f
4 00ba4ab3 21 0000067f
4 f81a8a93 21 00000600
5 00700b13 22 00000007
5 005b0b93 23 0000000c
5 003b9c13 24 00000060
5 0154fcb3 25 00000400
5 00a3ed33 26 ffffffff
5 40100db3 27 ffffff9c
5 7ff34e13 28 000007a2
5 0082de93 29 00fffff8
5 019c0f33 30 00000460
5 0ffd7f93 31 000000ff
6 03708013 0  0000009b
6 00d000b3 1  00000002
6 00006133 2  00000000
